//--- include/cnn_cfg.svh
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Input image held in ROM, square
`define CNN_IMG_W 30

// Convolution kernel side
`define CNN_K 3

// Output side of one convolution map
`define CNN_CONV_W 28

// Output side of one pooled map
`define CNN_POOL_W 14

// Filters in the first layer
`define CNN_NUM_FILT 6

// Pooled maps sit above the six convolution maps (6 x 784)
`define CNN_POOL_BASE 4704

// Shared by image, weight and bias ROMs
`define CNN_ROM_AW 10

// Covers convolution area plus pooled area
`define CNN_SRAM_AW 13

`endif

//--- logic/cnn_mem_pkg.sv
`include "cnn_cfg.svh"

package cnn_mem_pkg;

	typedef logic [`CNN_ROM_AW-1:0] rom_addr_t;
	typedef logic [`CNN_SRAM_AW-1:0] sram_addr_t;

	// One ROM port, image, weight or bias
	typedef struct packed {
		logic cs;
		logic oe;
		rom_addr_t addr;
	} rom_port_t;

	// SRAM port A, read only
	typedef struct packed {
		logic cen;
		sram_addr_t addr;
	} sram_rd_t;

	// SRAM port B, write
	typedef struct packed {
		logic cen;
		logic wen;
		sram_addr_t addr;
	} sram_wr_t;

	typedef logic [2:0] filt_idx_t; // 0 to 5
	typedef logic [4:0] coord_t; // Row or column, up to 27

endpackage

//--- logic/cnn_ctrl_pkg.sv
package cnn_ctrl_pkg;

	typedef enum logic [2:0] {
		sched_idle,
		sched_conv_load,
		sched_conv_run,
		sched_pool_load,
		sched_pool_run,
		sched_finish
	} sched_state_e;

	// conv_idle waits for the next map between filters
	typedef enum logic [2:0] {
		conv_idle,
		conv_read_w,
		conv_read_9,
		conv_read_c,
		conv_nop,
		conv_write
	} conv_state_e;

	typedef enum logic [1:0] {
		op_max_cmp = 2'd0,
		op_bias_add = 2'd2
	} adder_op_e;

	typedef enum logic [1:0] {
		sel_conv = 2'd0,
		sel_pool = 2'd2
	} result_sel_e;

	typedef struct packed {
		logic pool_en;
		adder_op_e adder_op;
		result_sel_e result_sel;
	} dp_ctrl_t;

	// Bit n drives PE row n+1
	typedef struct packed {
		logic [2:0] if_ld;
		logic [2:0] w_ld;
	} pe_load_t;

	typedef struct packed {
		cnn_mem_pkg::coord_t row; // Output position
		cnn_mem_pkg::coord_t col;
		cnn_mem_pkg::coord_t krow; // Offset of the pixel being fetched
		cnn_mem_pkg::coord_t kcol;
		logic fetch;
		logic write;
		logic first; // First window of the map, weights fetched too
	} conv_pos_t;

	typedef struct packed {
		cnn_mem_pkg::coord_t prow;
		cnn_mem_pkg::coord_t pcol;
		logic [1:0] quad; // Row offset in bit 1, column offset in bit 0
		logic rd;
		logic wr;
	} pool_pos_t;

endpackage

//--- logic/layer_scheduler.sv
`timescale 1ns/100ps
`include "cnn_cfg.svh"

module layer_scheduler (
	input logic clk,
	input logic rst,
	input logic start,
	input logic conv_done,
	input logic pool_done,
	output logic conv_go,
	output logic pool_go,
	output cnn_mem_pkg::filt_idx_t filt,
	output cnn_ctrl_pkg::sched_state_e state,
	output cnn_ctrl_pkg::dp_ctrl_t dp_ctrl,
	output logic done
);

	localparam cnn_mem_pkg::filt_idx_t last_filt = cnn_mem_pkg::filt_idx_t'(`CNN_NUM_FILT - 1);

	logic pool_phase;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cnn_ctrl_pkg::sched_idle;
			filt <= '0;
		end else begin
			case (state)
				cnn_ctrl_pkg::sched_idle, cnn_ctrl_pkg::sched_finish: begin
					if (start) begin // Also restarts from finish
						state <= cnn_ctrl_pkg::sched_conv_load;
						filt <= '0;
					end
				end
				cnn_ctrl_pkg::sched_conv_load: state <= cnn_ctrl_pkg::sched_conv_run;
				cnn_ctrl_pkg::sched_conv_run: begin
					if (conv_done) begin
						if (filt == last_filt) begin
							filt <= '0;
							state <= cnn_ctrl_pkg::sched_pool_load;
						end else begin
							filt <= filt + 1'b1;
							state <= cnn_ctrl_pkg::sched_conv_load;
						end
					end
				end
				cnn_ctrl_pkg::sched_pool_load: state <= cnn_ctrl_pkg::sched_pool_run;
				cnn_ctrl_pkg::sched_pool_run: begin
					if (pool_done) begin
						if (filt == last_filt) begin
							state <= cnn_ctrl_pkg::sched_finish;
						end else begin
							filt <= filt + 1'b1;
							state <= cnn_ctrl_pkg::sched_pool_load;
						end
					end
				end
				default: state <= cnn_ctrl_pkg::sched_idle;
			endcase
		end
	end

	assign conv_go = (state == cnn_ctrl_pkg::sched_conv_load); // One cycle per map
	assign pool_go = (state == cnn_ctrl_pkg::sched_pool_load);
	assign done = (state == cnn_ctrl_pkg::sched_finish);

	assign pool_phase = (state == cnn_ctrl_pkg::sched_pool_load) ||
		(state == cnn_ctrl_pkg::sched_pool_run);

	always_comb begin
		dp_ctrl.pool_en = (state == cnn_ctrl_pkg::sched_pool_run); // Qualified by the walker
		if (pool_phase) begin
			dp_ctrl.adder_op = cnn_ctrl_pkg::op_max_cmp;
			dp_ctrl.result_sel = cnn_ctrl_pkg::sel_pool;
		end else begin
			dp_ctrl.adder_op = cnn_ctrl_pkg::op_bias_add;
			dp_ctrl.result_sel = cnn_ctrl_pkg::sel_conv;
		end
	end

endmodule

//--- logic/conv_walker.sv
`timescale 1ns/100ps
`include "cnn_cfg.svh"

module conv_walker (
	input logic clk,
	input logic rst,
	input logic go,
	output cnn_ctrl_pkg::conv_pos_t pos,
	output cnn_ctrl_pkg::pe_load_t pe_load,
	output logic map_done
);

	localparam cnn_mem_pkg::coord_t last_pos = cnn_mem_pkg::coord_t'(`CNN_CONV_W - 1);
	localparam logic [3:0] last_fetch = 4'(`CNN_K * `CNN_K - 1);
	localparam logic [3:0] k_step = 4'(`CNN_K); // Next kernel row, same column
	localparam logic [3:0] new_col = 4'(`CNN_K - 1); // Rightmost kernel column

	cnn_ctrl_pkg::conv_state_e state;
	logic [3:0] fcnt;
	cnn_mem_pkg::coord_t row;
	cnn_mem_pkg::coord_t col;
	logic [1:0] krow;
	logic [1:0] kcol;
	logic fetch;
	logic first;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state <= cnn_ctrl_pkg::conv_idle;
			fcnt <= '0;
			row <= '0;
			col <= '0;
			map_done <= 1'b0;
		end else begin
			map_done <= 1'b0;
			case (state)
				cnn_ctrl_pkg::conv_idle: begin
					if (go) begin
						state <= cnn_ctrl_pkg::conv_read_w;
						fcnt <= '0;
						row <= '0;
						col <= '0;
					end
				end
				cnn_ctrl_pkg::conv_read_w, cnn_ctrl_pkg::conv_read_9: begin
					if (fcnt == last_fetch)
						state <= cnn_ctrl_pkg::conv_nop;
					else
						fcnt <= fcnt + 4'd1; // Full window, all nine pixels
				end
				cnn_ctrl_pkg::conv_read_c: begin
					if (fcnt == last_fetch)
						state <= cnn_ctrl_pkg::conv_nop;
					else
						fcnt <= fcnt + k_step; // New column only
				end
				cnn_ctrl_pkg::conv_nop: state <= cnn_ctrl_pkg::conv_write;
				cnn_ctrl_pkg::conv_write: begin
					if (col == last_pos) begin
						col <= '0;
						fcnt <= '0;
						if (row == last_pos) begin
							state <= cnn_ctrl_pkg::conv_idle;
							map_done <= 1'b1;
						end else begin
							row <= row + 1'b1;
							state <= cnn_ctrl_pkg::conv_read_9; // Row start refetches window
						end
					end else begin
						col <= col + 1'b1;
						fcnt <= new_col;
						state <= cnn_ctrl_pkg::conv_read_c;
					end
				end
				default: state <= cnn_ctrl_pkg::conv_idle;
			endcase
		end
	end

	// Fetch index to kernel row and column
	always_comb begin
		if (fcnt >= 2 * k_step) begin
			krow = 2'd2;
			kcol = 2'(fcnt - 2 * k_step);
		end else if (fcnt >= k_step) begin
			krow = 2'd1;
			kcol = 2'(fcnt - k_step);
		end else begin
			krow = 2'd0;
			kcol = 2'(fcnt);
		end
	end

	assign fetch = state inside {cnn_ctrl_pkg::conv_read_w, cnn_ctrl_pkg::conv_read_9,
		cnn_ctrl_pkg::conv_read_c};
	assign first = (state == cnn_ctrl_pkg::conv_read_w);

	always_comb begin
		pos.row = row;
		pos.col = col;
		pos.krow = cnn_mem_pkg::coord_t'(krow);
		pos.kcol = cnn_mem_pkg::coord_t'(kcol);
		pos.fetch = fetch;
		pos.write = (state == cnn_ctrl_pkg::conv_write);
		pos.first = first;
		pe_load.if_ld = fetch ? (3'b001 << krow) : 3'b000; // PE row of this pixel
		pe_load.w_ld = first ? pe_load.if_ld : 3'b000;
	end

endmodule

//--- logic/pool_walker.sv
`timescale 1ns/100ps
`include "cnn_cfg.svh"

module pool_walker (
	input logic clk,
	input logic rst,
	input logic go,
	output cnn_ctrl_pkg::pool_pos_t pos,
	output logic pool_en,
	output logic map_done
);

	localparam cnn_mem_pkg::coord_t last_pos = cnn_mem_pkg::coord_t'(`CNN_POOL_W - 1);

	logic active;
	logic wr;
	logic [1:0] quad;
	cnn_mem_pkg::coord_t prow;
	cnn_mem_pkg::coord_t pcol;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			active <= 1'b0;
			wr <= 1'b0;
			quad <= '0;
			prow <= '0;
			pcol <= '0;
			map_done <= 1'b0;
		end else begin
			map_done <= 1'b0;
			if (!active) begin
				if (go) begin
					active <= 1'b1;
					quad <= '0;
					prow <= '0;
					pcol <= '0;
				end
			end else if (!wr) begin
				quad <= quad + 2'd1;
				wr <= (quad == 2'd3); // Write after the fourth read
			end else begin
				wr <= 1'b0;
				if (pcol == last_pos) begin
					pcol <= '0;
					if (prow == last_pos) begin
						active <= 1'b0;
						map_done <= 1'b1;
					end else begin
						prow <= prow + 1'b1;
					end
				end else begin
					pcol <= pcol + 1'b1;
				end
			end
		end
	end

	assign pos.prow = prow;
	assign pos.pcol = pcol;
	assign pos.quad = quad;
	assign pos.rd = active & ~wr;
	assign pos.wr = active & wr;
	assign pool_en = pos.rd; // Comparator runs over the four reads

endmodule

//--- logic/mem_addr_gen.sv
`timescale 1ns/100ps
`include "cnn_cfg.svh"

module mem_addr_gen (
	input cnn_ctrl_pkg::sched_state_e state,
	input cnn_mem_pkg::filt_idx_t filt,
	input cnn_ctrl_pkg::conv_pos_t conv_pos,
	input cnn_ctrl_pkg::pool_pos_t pool_pos,
	output cnn_mem_pkg::rom_port_t rom_im,
	output cnn_mem_pkg::rom_port_t rom_w,
	output cnn_mem_pkg::rom_port_t rom_b,
	output cnn_mem_pkg::sram_rd_t sram_rd,
	output cnn_mem_pkg::sram_wr_t sram_wr
);

	localparam int calc_w = 16;

	logic conv_phase;
	logic pool_phase;
	logic [calc_w-1:0] img_a;
	logic [calc_w-1:0] fidx;
	logic [calc_w-1:0] w_a;
	logic [calc_w-1:0] conv_wr_a;
	logic [calc_w-1:0] pool_rd_a;
	logic [calc_w-1:0] pool_wr_a;

	// Constant multiply as a sum of shifted copies
	function automatic logic [calc_w-1:0] mul_const(input logic [calc_w-1:0] x,
		input int unsigned k);
		logic [calc_w-1:0] acc;
		acc = '0;
		for (int i = 0; i < calc_w; i++) begin
			if (k[i])
				acc = acc + (x << i);
		end
		return acc;
	endfunction

	assign conv_phase = state inside {cnn_ctrl_pkg::sched_conv_load, cnn_ctrl_pkg::sched_conv_run};
	assign pool_phase = state inside {cnn_ctrl_pkg::sched_pool_load, cnn_ctrl_pkg::sched_pool_run};

	assign img_a = mul_const(calc_w'(conv_pos.row) + calc_w'(conv_pos.krow), `CNN_IMG_W) +
		calc_w'(conv_pos.col) + calc_w'(conv_pos.kcol);
	assign fidx = mul_const(calc_w'(conv_pos.krow), `CNN_K) + calc_w'(conv_pos.kcol);
	assign w_a = mul_const(calc_w'(filt), `CNN_K * `CNN_K) + fidx;
	assign conv_wr_a = mul_const(calc_w'(filt), `CNN_CONV_W * `CNN_CONV_W) +
		mul_const(calc_w'(conv_pos.row), `CNN_CONV_W) + calc_w'(conv_pos.col);
	assign pool_rd_a = mul_const(calc_w'(filt), `CNN_CONV_W * `CNN_CONV_W) +
		mul_const((calc_w'(pool_pos.prow) << 1) + calc_w'(pool_pos.quad[1]), `CNN_CONV_W) +
		(calc_w'(pool_pos.pcol) << 1) + calc_w'(pool_pos.quad[0]);
	assign pool_wr_a = calc_w'(`CNN_POOL_BASE) +
		mul_const(calc_w'(filt), `CNN_POOL_W * `CNN_POOL_W) +
		mul_const(calc_w'(pool_pos.prow), `CNN_POOL_W) + calc_w'(pool_pos.pcol);

	always_comb begin
		rom_im.cs = conv_phase;
		rom_im.oe = conv_phase & conv_pos.fetch;
		rom_im.addr = img_a[`CNN_ROM_AW-1:0];
		rom_w.cs = conv_phase;
		rom_w.oe = conv_phase & conv_pos.fetch & conv_pos.first; // First window only
		rom_w.addr = w_a[`CNN_ROM_AW-1:0];
		rom_b.cs = conv_phase;
		rom_b.oe = conv_phase & (conv_pos.fetch | conv_pos.write);
		rom_b.addr = `CNN_ROM_AW'(filt); // One bias per filter
		sram_rd.cen = pool_phase;
		sram_rd.addr = pool_rd_a[`CNN_SRAM_AW-1:0];
		sram_wr.cen = conv_phase | pool_phase;
		if (pool_phase) begin
			sram_wr.wen = pool_pos.wr;
			sram_wr.addr = pool_wr_a[`CNN_SRAM_AW-1:0];
		end else begin
			sram_wr.wen = conv_phase & conv_pos.write;
			sram_wr.addr = conv_wr_a[`CNN_SRAM_AW-1:0];
		end
	end

endmodule

//--- logic/cnn_ctrl.sv
`timescale 1ns/100ps

module cnn_ctrl (
	input logic clk,
	input logic rst,
	input logic start,
	output logic done,
	output cnn_mem_pkg::rom_port_t rom_im,
	output cnn_mem_pkg::rom_port_t rom_w,
	output cnn_mem_pkg::rom_port_t rom_b,
	output cnn_mem_pkg::sram_rd_t sram_rd,
	output cnn_mem_pkg::sram_wr_t sram_wr,
	output cnn_ctrl_pkg::pe_load_t pe_load,
	output cnn_ctrl_pkg::dp_ctrl_t dp_ctrl
);

	logic conv_go;
	logic pool_go;
	logic conv_done;
	logic pool_done;
	logic pool_en;
	cnn_mem_pkg::filt_idx_t filt;
	cnn_ctrl_pkg::sched_state_e state;
	cnn_ctrl_pkg::dp_ctrl_t sched_dp;
	cnn_ctrl_pkg::conv_pos_t conv_pos;
	cnn_ctrl_pkg::pool_pos_t pool_pos;

	layer_scheduler u_sched (.clk(clk), .rst(rst), .start(start), .conv_done(conv_done),
		.pool_done(pool_done), .conv_go(conv_go), .pool_go(pool_go), .filt(filt),
		.state(state), .dp_ctrl(sched_dp), .done(done));

	conv_walker u_conv (.clk(clk), .rst(rst), .go(conv_go), .pos(conv_pos),
		.pe_load(pe_load), .map_done(conv_done));

	pool_walker u_pool (.clk(clk), .rst(rst), .go(pool_go), .pos(pool_pos),
		.pool_en(pool_en), .map_done(pool_done));

	mem_addr_gen u_addr (.state(state), .filt(filt), .conv_pos(conv_pos),
		.pool_pos(pool_pos), .rom_im(rom_im), .rom_w(rom_w), .rom_b(rom_b),
		.sram_rd(sram_rd), .sram_wr(sram_wr));

	// Pooling enable only on walker read cycles
	assign dp_ctrl = '{
		pool_en: sched_dp.pool_en & pool_en,
		adder_op: sched_dp.adder_op,
		result_sel: sched_dp.result_sel
	};

endmodule

//--- verification/cnn_ctrl_assert.sv
`timescale 1ns/100ps
`include "cnn_cfg.svh"

module cnn_ctrl_assert (
	input logic clk,
	input logic rst,
	input logic start,
	input logic done,
	input cnn_mem_pkg::rom_port_t rom_im,
	input cnn_mem_pkg::rom_port_t rom_w,
	input cnn_mem_pkg::rom_port_t rom_b,
	input cnn_mem_pkg::sram_rd_t sram_rd,
	input cnn_mem_pkg::sram_wr_t sram_wr,
	input cnn_ctrl_pkg::pe_load_t pe_load,
	input cnn_ctrl_pkg::dp_ctrl_t dp_ctrl
);

	int fail_cnt = 0; // Read by the testbench at the end
	logic started;
	logic quiet;
	logic pool_wr;

	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			started <= 1'b0;
		else if (start)
			started <= 1'b1;
	end

	assign quiet = !done && !rom_im.cs && !rom_im.oe && !rom_w.cs && !rom_w.oe &&
		!rom_b.cs && !rom_b.oe && !sram_rd.cen && !sram_wr.cen && !sram_wr.wen &&
		(pe_load == '0) && !dp_ctrl.pool_en;
	assign pool_wr = sram_wr.wen && (dp_ctrl.result_sel == cnn_ctrl_pkg::sel_pool);

	a_quiet: assert property (@(posedge clk) disable iff (rst) !started |-> quiet)
		else begin fail_cnt++; $error("memory or PE strobes active before first start"); end

	// Image window stays inside the 30x30 ROM area
	a_fetch: assert property (@(posedge clk) disable iff (rst)
		rom_im.oe |-> (int'(rom_im.addr) < `CNN_IMG_W * `CNN_IMG_W) && $onehot(pe_load.if_ld))
		else begin fail_cnt++; $error("bad image fetch address or PE row strobes"); end

	a_w_ld: assert property (@(posedge clk) disable iff (rst)
		(pe_load.w_ld & ~pe_load.if_ld) == 3'b000)
		else begin fail_cnt++; $error("weight strobe without its row input strobe"); end

	a_pool_rd: assert property (@(posedge clk) disable iff (rst)
		pool_wr |-> $past(dp_ctrl.pool_en, 1) && $past(dp_ctrl.pool_en, 2) &&
		$past(dp_ctrl.pool_en, 3) && $past(dp_ctrl.pool_en, 4))
		else begin fail_cnt++; $error("pooled write not preceded by four reads"); end

	a_pool_en: assert property (@(posedge clk) disable iff (rst)
		dp_ctrl.pool_en |-> sram_rd.cen && !sram_wr.wen)
		else begin fail_cnt++; $error("pool_en outside a pooling read"); end

	a_done: assert property (@(posedge clk) disable iff (rst) done && !start |=> done)
		else begin fail_cnt++; $error("done dropped without a new start"); end

endmodule

bind cnn_ctrl cnn_ctrl_assert u_chk (.*);

//--- verification/tb_cnn_ctrl.sv
`timescale 1ns/100ps
`include "cnn_cfg.svh"

module tb_cnn_ctrl;

	localparam int map_sz = `CNN_CONV_W * `CNN_CONV_W;
	localparam int conv_writes = `CNN_NUM_FILT * map_sz;
	localparam int pool_writes = `CNN_NUM_FILT * `CNN_POOL_W * `CNN_POOL_W;
	localparam int conv_row = 11 + (`CNN_CONV_W - 1) * 5; // First window 11, others 5
	localparam int run_len = `CNN_NUM_FILT * (`CNN_CONV_W * conv_row + 2 +
		`CNN_POOL_W * `CNN_POOL_W * 5 + 2);
	localparam int cycle_limit = 2 * run_len + 1000; // Two runs plus margin

	logic clk;
	logic rst;
	logic start;
	logic done;
	cnn_mem_pkg::rom_port_t rom_im;
	cnn_mem_pkg::rom_port_t rom_w;
	cnn_mem_pkg::rom_port_t rom_b;
	cnn_mem_pkg::sram_rd_t sram_rd;
	cnn_mem_pkg::sram_wr_t sram_wr;
	cnn_ctrl_pkg::pe_load_t pe_load;
	cnn_ctrl_pkg::dp_ctrl_t dp_ctrl;

	int err_cnt = 0;
	int conv_cnt = 0; // Convolution writes seen in this run
	int pool_cnt = 0;
	int rd_run = 0; // Pool reads since the last pooled write
	int runs = 0;
	logic done_q = 1'b0;

	cnn_ctrl dut0 (.clk(clk), .rst(rst), .start(start), .done(done), .rom_im(rom_im),
		.rom_w(rom_w), .rom_b(rom_b), .sram_rd(sram_rd), .sram_wr(sram_wr),
		.pe_load(pe_load), .dp_ctrl(dp_ctrl));

	initial clk = 1'b0;
	always #20 clk = ~clk;

	task automatic report_mismatch(input string msg);
		err_cnt++;
		$display("mismatch at %0t: %s", $time, msg);
	endtask

	task automatic check_conv_write();
		int f;
		f = conv_cnt / map_sz; // Filters already finished
		if (int'(sram_wr.addr) != conv_cnt)
			report_mismatch($sformatf("conv write address %0d, expected %0d",
				sram_wr.addr, conv_cnt));
		if (int'(rom_b.addr) != f)
			report_mismatch($sformatf("bias address %0d, expected %0d", rom_b.addr, f));
		if (int'(rom_w.addr) < f * 9 || int'(rom_w.addr) > f * 9 + 8)
			report_mismatch($sformatf("weight address %0d outside filter %0d", rom_w.addr, f));
		if (dp_ctrl.adder_op != cnn_ctrl_pkg::op_bias_add)
			report_mismatch("adder not in bias add on conv write");
		conv_cnt++;
	endtask

	task automatic check_pool_read();
		int per_map;
		int f;
		int pr;
		int pc;
		int exp_a;
		per_map = `CNN_POOL_W * `CNN_POOL_W;
		f = pool_cnt / per_map;
		pr = (pool_cnt % per_map) / `CNN_POOL_W;
		pc = pool_cnt % `CNN_POOL_W;
		// Top left, top right, bottom left, bottom right
		exp_a = f * map_sz + (2 * pr + rd_run / 2) * `CNN_CONV_W + 2 * pc + rd_run % 2;
		if (int'(sram_rd.addr) != exp_a)
			report_mismatch($sformatf("pool read address %0d, expected %0d",
				sram_rd.addr, exp_a));
		if (dp_ctrl.adder_op != cnn_ctrl_pkg::op_max_cmp)
			report_mismatch("adder not in max compare on pool read");
		rd_run++;
	endtask

	task automatic check_pool_write();
		if (rd_run != 4)
			report_mismatch($sformatf("%0d pool reads before write, expected 4", rd_run));
		rd_run = 0;
		if (int'(sram_wr.addr) != `CNN_POOL_BASE + pool_cnt)
			report_mismatch($sformatf("pool write address %0d, expected %0d",
				sram_wr.addr, `CNN_POOL_BASE + pool_cnt));
		pool_cnt++;
	endtask

	task automatic check_done_rise();
		if (conv_cnt != conv_writes || pool_cnt != pool_writes)
			report_mismatch($sformatf("done after %0d conv and %0d pool writes",
				conv_cnt, pool_cnt));
		conv_cnt = 0;
		pool_cnt = 0;
		runs++;
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk) begin
		if (!rst) begin
			if (dp_ctrl.pool_en && sram_rd.cen)
				check_pool_read();
			if (sram_wr.cen && sram_wr.wen) begin
				if (dp_ctrl.result_sel == cnn_ctrl_pkg::sel_conv)
					check_conv_write();
				else
					check_pool_write();
			end
			if (done && !done_q)
				check_done_rise();
			done_q = done;
		end
	end

	task automatic run_once();
		@(posedge clk);
		#2 start = 1'b1;
		@(posedge clk);
		#2 start = 1'b0;
		while (!done)
			@(posedge clk);
	endtask

	task automatic end_run(input logic timed_out);
		int afail;
		afail = dut0.u_chk.fail_cnt;
		$display("closing: %0d mismatches, %0d assertion failures, %0d runs done",
			err_cnt, afail, runs);
		if (!timed_out && err_cnt == 0 && afail == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		start = 1'b0;
		repeat (2) @(posedge clk);
		#2 rst = 1'b0;
		repeat (3) @(posedge clk);
		run_once();
		repeat (4) @(posedge clk); // done must hold here
		run_once();
		repeat (2) @(posedge clk);
		if (runs != 2) begin
			$display("only %0d of 2 runs reached done", runs);
			err_cnt++;
		end
		end_run(1'b0);
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		while (cycles < cycle_limit) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run still busy after %0d cycles", cycles);
		end_run(1'b1);
	end

endmodule

//--- cnn_ctrl.f
+incdir+include
logic/cnn_mem_pkg.sv
logic/cnn_ctrl_pkg.sv
logic/layer_scheduler.sv
logic/conv_walker.sv
logic/pool_walker.sv
logic/mem_addr_gen.sv
logic/cnn_ctrl.sv
verification/cnn_ctrl_assert.sv
verification/tb_cnn_ctrl.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and looks for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_cnn_ctrl -f cnn_ctrl.f -o sim_cnn_ctrl || exit 1
out=$(./obj_dir/sim_cnn_ctrl +verilator+error+limit+10000)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -q "ALL CHECKS PASSED" && exit 0 || exit 1
